//--- sim.f
+incdir+logic
logic/isa_pkg.sv
logic/core_pkg.sv
logic/ifu.sv
logic/idu.sv
logic/gpr.sv
logic/exu.sv
logic/processor_core.sv
testbench/tb_clock.sv
testbench/core_properties.sv
testbench/tb_processor_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_processor_core
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100

SOURCES := $(wildcard logic/*.sv logic/*.svh testbench/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tb_processor_core.sv
`default_nettype none
`timescale 1ns/100ps

module tb_processor_core;

    import isa_pkg::*;
    import core_pkg::*;

    localparam int RAND_LEN   = 64;
    localparam int DUMP_LEN   = 32;
    localparam int PROG_LEN   = RAND_LEN + DUMP_LEN + 1;
    localparam int MAX_STEPS  = 128;
    localparam int TIMEOUT_NS = (PROG_LEN + 40) * 2 * 4 * 2;

    localparam int K_ADD  = 0;
    localparam int K_SUB  = 1;
    localparam int K_AND  = 2;
    localparam int K_OR   = 3;
    localparam int K_XOR  = 4;
    localparam int K_SLT  = 5;
    localparam int K_ADDI = 6;
    localparam int K_ANDI = 7;
    localparam int K_ORI  = 8;
    localparam int K_XORI = 9;
    localparam int K_LUI  = 10;
    localparam int K_LW   = 11;
    localparam int K_SW   = 12;
    localparam int K_BEQ  = 13;
    localparam int K_BNE  = 14;
    localparam int K_JAL  = 15;

    logic      clk;
    logic      arst_n;
    word_t     mem_r_1;
    word_t     mem_r_1_addr;
    word_t     mem_r_2;
    word_t     mem_r_2_addr;
    word_t     mem_w;
    word_t     mem_w_addr;
    logic      mem_w_en;

    // 4 KB of shared instruction and data memory
    word_t     mem [0:1023];
    word_t     ref_mem [0:1023];
    word_t     x [0:31];
    int        p_kind [0:PROG_LEN-1];
    reg_addr_t p_rd [0:PROG_LEN-1];
    reg_addr_t p_rs1 [0:PROG_LEN-1];
    reg_addr_t p_rs2 [0:PROG_LEN-1];
    word_t     p_imm [0:PROG_LEN-1];
    word_t     exp_pc [0:MAX_STEPS-1];
    dmem_req_t exp_st [0:MAX_STEPS-1];
    int        n_steps;
    word_t     lfsr = 32'hdd2d_27da;
    int        fetch_errors = 0;
    int        store_errors = 0;
    word_t     wr_addr;
    word_t     wr_data;

    tb_clock clock_i (
        .clk ( clk )
    );

    processor_core processor_core_i (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .mem_r_1      ( mem_r_1      ),
        .mem_r_1_addr ( mem_r_1_addr ),
        .mem_r_2      ( mem_r_2      ),
        .mem_r_2_addr ( mem_r_2_addr ),
        .mem_w        ( mem_w        ),
        .mem_w_addr   ( mem_w_addr   ),
        .mem_w_en     ( mem_w_en     )
    );

    bind processor_core core_properties props_i (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .mem_r_1_addr ( mem_r_1_addr ),
        .mem_w_addr   ( mem_w_addr   ),
        .mem_w_en     ( mem_w_en     )
    );

    assign mem_r_1 = mem[mem_r_1_addr[11:2]];
    assign mem_r_2 = mem[mem_r_2_addr[11:2]];

    // store lands half a step after the edge
    always @(posedge clk) begin
        if (mem_w_en) begin
            wr_addr = mem_w_addr;
            wr_data = mem_w;
            #0.5;
            mem[wr_addr[11:2]] = wr_data;
        end
    end

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic word_t sext12(input word_t b);
        return {{20{b[11]}}, b[11:0]};
    endfunction

    function automatic word_t fill_word(input word_t addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], ~addr[15:0]};
    endfunction

    function automatic logic [2:0] f3_of(input int kind);
        case (kind)
            K_AND, K_ANDI: return F3_AND;
            K_OR, K_ORI:   return F3_OR;
            K_XOR, K_XORI: return F3_XOR;
            K_SLT:         return F3_SLT;
            default:       return F3_ADD;
        endcase
    endfunction

    function automatic word_t encode(input int kind, input reg_addr_t rd, input reg_addr_t rs1,
                                     input reg_addr_t rs2, input word_t imm);
        inst_u w;
        w = '0;
        case (kind)
            K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT: begin
                w.r_fmt.funct7 = (kind == K_SUB) ? F7_SUB : 7'b0;
                w.r_fmt.rs2    = rs2;
                w.r_fmt.rs1    = rs1;
                w.r_fmt.funct3 = f3_of(kind);
                w.r_fmt.rd     = rd;
                w.r_fmt.opcode = OP;
            end
            K_ADDI, K_ANDI, K_ORI, K_XORI, K_LW: begin
                w.i_fmt.imm12  = imm[11:0];
                w.i_fmt.rs1    = rs1;
                w.i_fmt.funct3 = (kind == K_LW) ? F3_WORD : f3_of(kind);
                w.i_fmt.rd     = rd;
                w.i_fmt.opcode = (kind == K_LW) ? LOAD : OP_IMM;
            end
            K_LUI: begin
                {w.r_fmt.funct7, w.r_fmt.rs2, w.r_fmt.rs1, w.r_fmt.funct3} = imm[31:12];
                w.r_fmt.rd     = rd;
                w.r_fmt.opcode = LUI;
            end
            K_SW: begin
                w.s_fmt.imm_hi = imm[11:5];
                w.s_fmt.rs2    = rs2;
                w.s_fmt.rs1    = rs1;
                w.s_fmt.funct3 = F3_WORD;
                w.s_fmt.imm_lo = imm[4:0];
                w.s_fmt.opcode = STORE;
            end
            K_BEQ, K_BNE: begin
                w.s_fmt.imm_hi = {imm[12], imm[10:5]};
                w.s_fmt.rs2    = rs2;
                w.s_fmt.rs1    = rs1;
                w.s_fmt.funct3 = (kind == K_BNE) ? F3_BNE : F3_BEQ;
                w.s_fmt.imm_lo = {imm[4:1], imm[11]};
                w.s_fmt.opcode = BRANCH;
            end
            default: begin
                // JAL
                w.i_fmt.imm12  = {imm[20], imm[10:1], imm[11]};
                w.i_fmt.rs1    = imm[19:15];
                w.i_fmt.funct3 = imm[14:12];
                w.i_fmt.rd     = rd;
                w.i_fmt.opcode = JAL;
            end
        endcase
        return w;
    endfunction

    function automatic word_t alu_ref(input int kind, input word_t a, input word_t b);
        case (kind)
            K_SUB:         return a - b;
            K_AND, K_ANDI: return a & b;
            K_OR, K_ORI:   return a | b;
            K_XOR, K_XORI: return a ^ b;
            K_SLT:         return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:       return a + b;
        endcase
    endfunction

    function automatic dmem_req_t sample_dmem();
        return '{r_addr: mem_r_2_addr, w_addr: mem_w_addr, w_data: mem_w, w_en: mem_w_en};
    endfunction

    task automatic set_inst(input int i, input int kind, input reg_addr_t rd,
                            input reg_addr_t rs1, input reg_addr_t rs2, input word_t imm);
        p_kind[i] = kind;
        p_rd[i]   = rd;
        p_rs1[i]  = rs1;
        p_rs2[i]  = rs2;
        p_imm[i]  = imm;
        mem[i]    = encode(kind, rd, rs1, rs2, imm);
    endtask

    task automatic build_program();
        int        kind;
        int        off;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     imm;
        word_t     last_sw;
        logic      have_sw;
        last_sw = '0;
        have_sw = 1'b0;
        for (int i = 0; i < RAND_LEN; i++) begin
            kind = int'(rand_bits(4));
            rd   = reg_addr_t'(rand_bits(5));
            rs1  = reg_addr_t'(rand_bits(5));
            rs2  = reg_addr_t'(rand_bits(5));
            imm  = sext12(rand_bits(12));
            case (kind)
                K_LUI: imm = rand_bits(20) << 12;
                K_LW, K_SW: begin
                    rs1 = '0;
                    imm = 32'h400 + (rand_bits(6) << 2);
                    // loads often read back the latest store
                    if (kind == K_LW && have_sw && rand_bits(1) == 1) begin
                        imm = last_sw;
                    end
                    if (kind == K_SW) begin
                        last_sw = imm;
                        have_sw = 1'b1;
                    end
                end
                K_BEQ, K_BNE, K_JAL: begin
                    // forward only and at most up to the first dump store
                    off = int'(rand_bits(2)) + 1;
                    if (off > RAND_LEN - i) begin
                        off = RAND_LEN - i;
                    end
                    imm = word_t'(off * 4);
                    // equal operands now and then so branches go both ways
                    if (rand_bits(1) == 1) begin
                        rs2 = rs1;
                    end
                end
                default: ;
            endcase
            set_inst(i, kind, rd, rs1, rs2, imm);
        end
        for (int n = 0; n < DUMP_LEN; n++) begin
            set_inst(RAND_LEN + n, K_SW, '0, '0, reg_addr_t'(n), word_t'(32'h600 + n * 4));
        end
        set_inst(PROG_LEN - 1, K_JAL, '0, '0, '0, '0);
    endtask

    task automatic run_model();
        word_t pc;
        word_t next;
        word_t a;
        word_t b;
        word_t r;
        word_t addr;
        int    idx;
        int    k;
        int    halts;
        logic  wr;
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        for (int i = 0; i < 1024; i++) begin
            ref_mem[i] = fill_word(word_t'(i << 2));
        end
        pc      = '0;
        n_steps = 0;
        halts   = 0;
        // the final self jump is seen twice
        while (halts < 2 && n_steps < MAX_STEPS) begin
            idx  = int'(pc >> 2);
            k    = p_kind[idx];
            a    = x[p_rs1[idx]];
            b    = x[p_rs2[idx]];
            r    = '0;
            next = pc + 32'd4;
            wr   = 1'b1;
            exp_pc[n_steps] = pc;
            exp_st[n_steps] = '0;
            case (k)
                K_LUI: r = p_imm[idx];
                K_LW: begin
                    addr = a + p_imm[idx];
                    r    = ref_mem[addr[11:2]];
                end
                K_SW: begin
                    addr = a + p_imm[idx];
                    wr   = 1'b0;
                    ref_mem[addr[11:2]] = b;
                    exp_st[n_steps] = '{r_addr: addr, w_addr: addr, w_data: b, w_en: 1'b1};
                end
                K_BEQ, K_BNE: begin
                    wr = 1'b0;
                    if ((a == b) == (k == K_BEQ)) begin
                        next = pc + p_imm[idx];
                    end
                end
                K_JAL: begin
                    r    = pc + 32'd4;
                    next = pc + p_imm[idx];
                    if (p_imm[idx] == '0) begin
                        halts++;
                    end
                end
                default: r = alu_ref(k, a, (k >= K_ADDI) ? p_imm[idx] : b);
            endcase
            if (wr && p_rd[idx] != '0) begin
                x[p_rd[idx]] = r;
            end
            pc = next;
            n_steps++;
        end
    endtask

    task automatic check_fetch(input word_t got, input word_t exp, input int step);
        if (got !== exp) begin
            fetch_errors++;
            $display("MISMATCH at %0t: fetch address in step %0d is %h, expected %h",
                     $time, step, got, exp);
        end
    endtask

    task automatic check_store(input dmem_req_t got, input dmem_req_t exp, input int step);
        if (exp.w_en) begin
            if (got !== exp) begin
                store_errors++;
                $display("MISMATCH at %0t: step %0d store %h <- %h (en %b), expected %h <- %h",
                         $time, step, got.w_addr, got.w_data, got.w_en, exp.w_addr, exp.w_data);
            end
        end else if (got.w_en !== 1'b0) begin
            store_errors++;
            $display("MISMATCH at %0t: mem_w_en is %b in step %0d, expected 0",
                     $time, got.w_en, step);
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the core did not get through the program within %0d ns",
                 TIMEOUT_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        arst_n = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = fill_word(word_t'(i << 2));
        end
        build_program();
        run_model();
        repeat (3) @(posedge clk);
        #0.5;
        arst_n = 1'b1;
        // sample mid-cycle in the fetch and the execute cycle of each step
        for (int s = 0; s < n_steps; s++) begin
            @(negedge clk);
            check_fetch(mem_r_1_addr, exp_pc[s], s);
            check_store(sample_dmem(), '0, s);
            @(negedge clk);
            check_fetch(mem_r_1_addr, exp_pc[s], s);
            check_store(sample_dmem(), exp_st[s], s);
        end
        $display("errors: fetch %0d, store %0d, assertion %0d", fetch_errors, store_errors,
                 processor_core_i.props_i.fail_count);
        if (fetch_errors == 0 && store_errors == 0
                && processor_core_i.props_i.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/core_properties.sv
`default_nettype none
`timescale 1ns/100ps

module core_properties (
    input wire                 clk,
    input wire                 arst_n,
    input wire isa_pkg::word_t mem_r_1_addr,
    input wire isa_pkg::word_t mem_w_addr,
    input wire                 mem_w_en
);

    int unsigned fail_count = 0;

    fetch_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        mem_r_1_addr[1:0] == 2'b00)
    else begin
        fail_count++;
        $error("fetch address %h is not word aligned", mem_r_1_addr);
    end

    // a store needs an execute cycle, so never two in a row
    no_back_to_back_write: assert property (@(posedge clk) disable iff (!arst_n)
        mem_w_en |=> !mem_w_en)
    else begin
        fail_count++;
        $error("mem_w_en high in two consecutive cycles");
    end

    quiet_after_reset: assert property (@(posedge clk)
        $rose(arst_n) |-> !mem_w_en)
    else begin
        fail_count++;
        $error("mem_w_en high in the first cycle after reset");
    end

    store_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        mem_w_en |-> mem_w_addr[1:0] == 2'b00)
    else begin
        fail_count++;
        $error("store address %h is not word aligned", mem_w_addr);
    end

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`default_nettype none
`timescale 1ns/100ps

module tb_clock #(
    parameter int HALF_PERIOD_NS = 2
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- logic/processor_core.sv
`default_nettype none
`timescale 1ns/100ps

module processor_core (
    input  wire            clk,
    input  wire            arst_n,
    input  wire            isa_pkg::word_t mem_r_1,
    output isa_pkg::word_t mem_r_1_addr,
    input  wire            isa_pkg::word_t mem_r_2,
    output isa_pkg::word_t mem_r_2_addr,
    output isa_pkg::word_t mem_w,
    output isa_pkg::word_t mem_w_addr,
    output logic           mem_w_en
);

    import isa_pkg::*;
    import core_pkg::*;

    word_t     pc;
    word_t     next_pc;
    logic      exec;
    inst_u     inst;
    decoded_t  dec;
    word_t     src1;
    word_t     src2;
    logic      rd_w_en;
    word_t     rd_data;
    dmem_req_t dmem;

    ifu ifu_1 (
        .clk     ( clk     ),
        .arst_n  ( arst_n  ),
        .next_pc ( next_pc ),
        .mem_r   ( mem_r_1 ),
        .pc      ( pc      ),
        .exec    ( exec    ),
        .inst    ( inst    )
    );

    idu idu_1 (
        .inst ( inst ),
        .dec  ( dec  )
    );

    gpr gpr_1 (
        .clk     ( clk     ),
        .arst_n  ( arst_n  ),
        .w_en    ( rd_w_en ),
        .w_addr  ( dec.rd  ),
        .w_data  ( rd_data ),
        .r1_addr ( dec.rs1 ),
        .r2_addr ( dec.rs2 ),
        .r1_data ( src1    ),
        .r2_data ( src2    )
    );

    exu exu_1 (
        .exec    ( exec    ),
        .pc      ( pc      ),
        .dec     ( dec     ),
        .src1    ( src1    ),
        .src2    ( src2    ),
        .mem_r   ( mem_r_2 ),
        .next_pc ( next_pc ),
        .rd_w_en ( rd_w_en ),
        .rd_data ( rd_data ),
        .dmem    ( dmem    )
    );

    assign mem_r_1_addr = pc;
    assign mem_r_2_addr = dmem.r_addr;
    assign mem_w_addr   = dmem.w_addr;
    assign mem_w        = dmem.w_data;
    assign mem_w_en     = dmem.w_en;

endmodule

`default_nettype wire

//--- logic/exu.sv
`default_nettype none
`timescale 1ns/100ps

module exu (
    input  wire                 exec,
    input  wire                 isa_pkg::word_t pc,
    input  wire                 core_pkg::decoded_t dec,
    input  wire                 isa_pkg::word_t src1,
    input  wire                 isa_pkg::word_t src2,
    input  wire                 isa_pkg::word_t mem_r,
    output isa_pkg::word_t      next_pc,
    output logic                rd_w_en,
    output isa_pkg::word_t      rd_data,
    output core_pkg::dmem_req_t dmem
);

    import isa_pkg::*;
    import core_pkg::*;

    word_t op_b;
    word_t alu_y;
    word_t pc_plus4;
    logic  src_eq;
    logic  taken;

    assign op_b = dec.ctrl.use_imm ? dec.imm : src2;

    always_comb begin
        case (dec.ctrl.alu_op)
            ALU_ADD:    alu_y = src1 + op_b;
            ALU_SUB:    alu_y = src1 - op_b;
            ALU_AND:    alu_y = src1 & op_b;
            ALU_OR:     alu_y = src1 | op_b;
            ALU_XOR:    alu_y = src1 ^ op_b;
            ALU_SLT:    alu_y = word_t'($signed(src1) < $signed(op_b));
            ALU_PASS_B: alu_y = op_b;
            default:    alu_y = '0;
        endcase
    end

    // branch compare uses both registers and never the immediate
    assign src_eq   = src1 == src2;
    assign taken    = dec.ctrl.jump | (dec.ctrl.branch & (src_eq ^ dec.ctrl.branch_ne));
    assign pc_plus4 = pc + 32'd4;
    assign next_pc  = taken ? pc + dec.imm : pc_plus4;

    always_comb begin
        if (dec.ctrl.jump) begin
            rd_data = pc_plus4;
        end else if (dec.ctrl.mem_read) begin
            rd_data = mem_r;
        end else begin
            rd_data = alu_y;
        end
    end

    assign rd_w_en = exec & dec.ctrl.reg_write;

    // loads and stores decode to ALU_ADD with imm, so alu_y is src1 + imm
    assign dmem = '{
        r_addr: alu_y,
        w_addr: alu_y,
        w_data: src2,
        w_en:   exec & dec.ctrl.mem_write
    };

endmodule

`default_nettype wire

//--- logic/gpr.sv
`default_nettype none
`timescale 1ns/100ps

`include "core_config.svh"

module gpr (
    input  wire            clk,
    input  wire            arst_n,
    input  wire            w_en,
    input  wire            core_pkg::reg_addr_t w_addr,
    input  wire            isa_pkg::word_t w_data,
    input  wire            core_pkg::reg_addr_t r1_addr,
    input  wire            core_pkg::reg_addr_t r2_addr,
    output isa_pkg::word_t r1_data,
    output isa_pkg::word_t r2_data
);

    import isa_pkg::*;

    // no storage behind x0
    word_t regs [1:`GPR_NUM-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < `GPR_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (w_en && w_addr != '0) begin
            regs[w_addr] <= w_data;
        end
    end

    assign r1_data = (r1_addr == '0) ? '0 : regs[r1_addr];
    assign r2_data = (r2_addr == '0) ? '0 : regs[r2_addr];

endmodule

`default_nettype wire

//--- logic/idu.sv
`default_nettype none
`timescale 1ns/100ps

module idu (
    input  wire              isa_pkg::inst_u inst,
    output core_pkg::decoded_t dec
);

    import isa_pkg::*;
    import core_pkg::*;

    function automatic alu_op_t alu_sel(input logic [2:0] funct3, input logic sub);
        case (funct3)
            F3_ADD:  return sub ? ALU_SUB : ALU_ADD;
            F3_SLT:  return ALU_SLT;
            F3_XOR:  return ALU_XOR;
            F3_OR:   return ALU_OR;
            F3_AND:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    assign imm_i = {{20{inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
    assign imm_s = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};

    // B reuses the S fields with bit 11 moved to imm_lo[0]
    assign imm_b = {{19{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi[6], inst.s_fmt.imm_lo[0],
                    inst.s_fmt.imm_hi[5:0], inst.s_fmt.imm_lo[4:1], 1'b0};

    assign imm_u = {inst.r_fmt.funct7, inst.r_fmt.rs2, inst.r_fmt.rs1, inst.r_fmt.funct3,
                    12'b0};

    // J bits 19:12 sit where rs1 and funct3 are
    assign imm_j = {{11{inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12[11], inst.i_fmt.rs1,
                    inst.i_fmt.funct3, inst.i_fmt.imm12[0], inst.i_fmt.imm12[10:1], 1'b0};

    always_comb begin
        dec     = '0;
        dec.rd  = inst.r_fmt.rd;
        dec.rs1 = inst.r_fmt.rs1;
        dec.rs2 = inst.s_fmt.rs2;
        case (inst.r_fmt.opcode)
            OP: begin
                dec.ctrl.reg_write = 1'b1;
                dec.ctrl.alu_op    = alu_sel(inst.r_fmt.funct3, inst.r_fmt.funct7 == F7_SUB);
            end
            OP_IMM: begin
                dec.ctrl.reg_write = 1'b1;
                dec.ctrl.use_imm   = 1'b1;
                dec.ctrl.alu_op    = alu_sel(inst.i_fmt.funct3, 1'b0);
                dec.imm            = imm_i;
            end
            LUI: begin
                dec.ctrl.reg_write = 1'b1;
                dec.ctrl.use_imm   = 1'b1;
                dec.ctrl.alu_op    = ALU_PASS_B;
                dec.imm            = imm_u;
            end
            LOAD: begin
                dec.ctrl.reg_write = 1'b1;
                dec.ctrl.mem_read  = 1'b1;
                dec.ctrl.use_imm   = 1'b1;
                dec.ctrl.alu_op    = ALU_ADD;
                dec.imm            = imm_i;
            end
            STORE: begin
                dec.ctrl.mem_write = 1'b1;
                dec.ctrl.use_imm   = 1'b1;
                dec.ctrl.alu_op    = ALU_ADD;
                dec.imm            = imm_s;
            end
            BRANCH: begin
                dec.ctrl.branch    = 1'b1;
                dec.ctrl.branch_ne = inst.s_fmt.funct3 == F3_BNE;
                dec.imm            = imm_b;
            end
            JAL: begin
                dec.ctrl.reg_write = 1'b1;
                dec.ctrl.jump      = 1'b1;
                dec.imm            = imm_j;
            end
            // unknown opcode runs as a no-op
            default: dec.ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/ifu.sv
`default_nettype none
`timescale 1ns/100ps

module ifu (
    input  wire            clk,
    input  wire            arst_n,
    input  wire            isa_pkg::word_t next_pc,
    input  wire            isa_pkg::word_t mem_r,
    output isa_pkg::word_t pc,
    output logic           exec,
    output isa_pkg::inst_u inst
);

    // fetch and execute alternate every cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc   <= '0;
            exec <= 1'b0;
            inst <= '0;
        end else begin
            exec <= ~exec;
            if (exec) begin
                pc <= next_pc;
            end else begin
                // instruction port answers in the fetch cycle
                inst <= mem_r;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/core_pkg.sv
`default_nettype none

`include "core_config.svh"

package core_pkg;

    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    branch_ne;
        logic    jump;
    } ctrl_t;

    // imm is sign-extended already
    typedef struct packed {
        ctrl_t          ctrl;
        reg_addr_t      rd;
        reg_addr_t      rs1;
        reg_addr_t      rs2;
        isa_pkg::word_t imm;
    } decoded_t;

    typedef struct packed {
        isa_pkg::word_t r_addr;
        isa_pkg::word_t w_addr;
        isa_pkg::word_t w_data;
        logic           w_en;
    } dmem_req_t;

endpackage

`default_nettype wire

//--- logic/isa_pkg.sv
`default_nettype none

`include "core_config.svh"

package isa_pkg;

    typedef logic [`ISA_WIDTH-1:0] word_t;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_t;

    typedef struct packed {
        logic [6:0]                 funct7;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                 funct3;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        opcode_t                    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]                imm12;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                 funct3;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        opcode_t                    opcode;
    } i_fmt_t;

    // B format shares this layout with its bits reshuffled in decode
    typedef struct packed {
        logic [6:0]                 imm_hi;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                 funct3;
        logic [4:0]                 imm_lo;
        opcode_t                    opcode;
    } s_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
    } inst_u;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_WORD = 3'b010;

    localparam logic [6:0] F7_SUB  = 7'b0100000;

endpackage

`default_nettype wire

//--- logic/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// data and address word
`define ISA_WIDTH 32

// register index and register count
`define REG_ADDR_WIDTH 5
`define GPR_NUM 32

`endif
